// ==== logic/rvfi_check_pkg.sv ====
// shared record, pair and report types for the retirement checker, used by the rtl and testbench
`default_nettype none

package rvfi_check_pkg;

  // data and address width of a retirement record
  localparam int xlen = 32;

  // width of the pair number and of the running counters
  localparam int seq_w = 16;

  // one retirement as carried on rvfi, with a single memory access
  typedef struct packed {
    logic [xlen-1:0]   pc_rdata;
    logic [xlen-1:0]   insn;
    logic              trap;
    logic              halt;
    logic [2:0]        dbg;
    logic              dbg_mode;
    logic              nmip;
    logic              intr;
    logic [1:0]        mode;
    logic [4:0]        rd1_addr;
    logic [xlen-1:0]   rd1_wdata;
    logic [xlen-1:0]   mem_addr;
    logic [xlen/8-1:0] mem_rmask;
    logic [xlen/8-1:0] mem_wmask;
    logic [xlen-1:0]   mem_rdata;
    logic [xlen-1:0]   mem_wdata;
  } rvfi_rec_t;

  // compared fields, declaration order is the check priority
  typedef enum logic [4:0] {
    field_none,
    field_pc,
    field_insn,
    field_trap,
    field_halt,
    field_dbg,
    field_dbg_mode,
    field_nmip,
    field_intr,
    field_mode,
    field_rd_addr,
    field_rd_wdata,
    field_mem_rmask,
    field_mem_wmask,
    field_mem_addr,
    field_mem_rdata,
    field_mem_wdata
  } rvfi_field_e;

  // core and reference retirement of the same order
  typedef struct packed {
    logic [seq_w-1:0] seq;
    rvfi_rec_t        core;
    rvfi_rec_t        rm;
  } rvfi_pair_t;

  // first failing field of a pair, values zero-extended
  typedef struct packed {
    logic [seq_w-1:0] seq;
    rvfi_field_e      field;
    logic [xlen-1:0]  core_val;
    logic [xlen-1:0]  rm_val;
  } rvfi_report_t;

endpackage

`default_nettype wire

// ==== logic/retire_fifo.sv ====
// credit-returning retirement record buffer, one instance per trace source
`timescale 1ns/100ps
`default_nettype none

module retire_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire                        rvfi_core,
  input  wire                        rst_n_i,
  input  wire                        valid_i,
  input  rvfi_check_pkg::rvfi_rec_t  rec_i,
  input  wire                        pop_i,
  output rvfi_check_pkg::rvfi_rec_t  head_o,
  output logic                       avail_o,
  output logic                       credit_o
);

  localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

  rvfi_check_pkg::rvfi_rec_t mem_q [FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full    = (count_q == cnt_w'(FIFO_DEPTH));
  assign avail_o = (count_q != '0);
  assign wr_en   = valid_i && !full;
  assign rd_en   = pop_i && avail_o;
  assign head_o  = mem_q[rd_ptr_q];

  // pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge rvfi_core or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + cnt_w'(wr_en) - cnt_w'(rd_en);
      // one credit back to the sender per freed slot
      credit_o <= rd_en;
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  // a sender spends a credit per record, so it can never find the buffer full
  no_overflow_a: assert property (@(posedge rvfi_core) disable iff (!rst_n_i)
    valid_i |-> !full);

  // the pairer only pops a head that is present
  no_underflow_a: assert property (@(posedge rvfi_core) disable iff (!rst_n_i)
    pop_i |-> avail_o);

endmodule

`default_nettype wire

// ==== logic/retire_pairer.sv ====
// joins the core and reference retirement streams in order and numbers each pair
`timescale 1ns/100ps
`default_nettype none

module retire_pairer (
  input  wire                         rvfi_core,
  input  wire                         rst_n_i,
  input  rvfi_check_pkg::rvfi_rec_t   core_head_i,
  input  wire                         core_avail_i,
  input  rvfi_check_pkg::rvfi_rec_t   rm_head_i,
  input  wire                         rm_avail_i,
  output logic                        pop_o,
  output logic                        pair_valid_o,
  output rvfi_check_pkg::rvfi_pair_t  pair_o
);

  logic [rvfi_check_pkg::seq_w-1:0] seq_q;

  // both heads pop together, so the n-th core record meets the n-th rm record
  assign pop_o        = core_avail_i && rm_avail_i;
  assign pair_valid_o = pop_o;

  always_comb begin
    pair_o.seq  = seq_q;
    pair_o.core = core_head_i;
    pair_o.rm   = rm_head_i;
  end

  // pair number counts from zero after reset and wraps
  always_ff @(posedge rvfi_core or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seq_q <= '0;
    end else if (pop_o) begin
      seq_q <= seq_q + 1'b1;
    end
  end

  // a pop always finds a record in both buffers
  pop_both_a: assert property (@(posedge rvfi_core) disable iff (!rst_n_i)
    pop_o |-> core_avail_i && rm_avail_i);

endmodule

`default_nettype wire

// ==== logic/retire_comparator.sv ====
// compares each retirement pair under the masking rules and registers one report per pair
`timescale 1ns/100ps
`default_nettype none

module retire_comparator (
  input  wire                                rvfi_core,
  input  wire                                rst_n_i,
  input  wire                                pair_valid_i,
  input  rvfi_check_pkg::rvfi_pair_t         pair_i,
  output logic                               report_valid_o,
  output rvfi_check_pkg::rvfi_report_t       report_o,
  output logic [rvfi_check_pkg::seq_w-1:0]   compared_cnt_o,
  output logic [rvfi_check_pkg::seq_w-1:0]   mismatch_cnt_o
);

  localparam int xlen     = rvfi_check_pkg::xlen;
  localparam int n_fields = int'(rvfi_check_pkg::field_mem_wdata) + 1;

  // one xlen value per field, indexed by the field enum
  typedef logic [n_fields-1:0][xlen-1:0] field_vals_t;

  rvfi_check_pkg::rvfi_rec_t    core_rec;
  rvfi_check_pkg::rvfi_rec_t    rm_rec;
  logic [xlen-1:0]              rbyte_mask;
  logic [xlen-1:0]              wbyte_mask;
  field_vals_t                  core_v;
  field_vals_t                  rm_v;
  logic [n_fields-1:0]          check_en;
  rvfi_check_pkg::rvfi_field_e  fail_field;
  rvfi_check_pkg::rvfi_report_t report_d;

  function automatic logic [xlen-1:0] byte_mask(input logic [xlen/8-1:0] sel);
    logic [xlen-1:0] m;
    for (int i = 0; i < xlen / 8; i++) begin
      m[i*8 +: 8] = {8{sel[i]}};
    end
    return m;
  endfunction

  // memory data is seen only through the core's byte masks
  function automatic field_vals_t field_vals(input rvfi_check_pkg::rvfi_rec_t rec,
                                             input logic [xlen-1:0] rmask,
                                             input logic [xlen-1:0] wmask);
    field_vals_t v;
    v = '0;
    v[rvfi_check_pkg::field_pc]        = rec.pc_rdata;
    v[rvfi_check_pkg::field_insn]      = rec.insn;
    v[rvfi_check_pkg::field_trap]      = xlen'(rec.trap);
    v[rvfi_check_pkg::field_halt]      = xlen'(rec.halt);
    v[rvfi_check_pkg::field_dbg]       = xlen'(rec.dbg);
    v[rvfi_check_pkg::field_dbg_mode]  = xlen'(rec.dbg_mode);
    v[rvfi_check_pkg::field_nmip]      = xlen'(rec.nmip);
    v[rvfi_check_pkg::field_intr]      = xlen'(rec.intr);
    v[rvfi_check_pkg::field_mode]      = xlen'(rec.mode);
    v[rvfi_check_pkg::field_rd_addr]   = xlen'(rec.rd1_addr);
    v[rvfi_check_pkg::field_rd_wdata]  = rec.rd1_wdata;
    v[rvfi_check_pkg::field_mem_rmask] = xlen'(rec.mem_rmask);
    v[rvfi_check_pkg::field_mem_wmask] = xlen'(rec.mem_wmask);
    v[rvfi_check_pkg::field_mem_addr]  = rec.mem_addr;
    v[rvfi_check_pkg::field_mem_rdata] = rec.mem_rdata & rmask;
    v[rvfi_check_pkg::field_mem_wdata] = rec.mem_wdata & wmask;
    return v;
  endfunction

  assign core_rec   = pair_i.core;
  assign rm_rec     = pair_i.rm;
  assign rbyte_mask = byte_mask(core_rec.mem_rmask);
  assign wbyte_mask = byte_mask(core_rec.mem_wmask);
  assign core_v     = field_vals(core_rec, rbyte_mask, wbyte_mask);
  assign rm_v       = field_vals(rm_rec, rbyte_mask, wbyte_mask);

  always_comb begin
    check_en = '1;
    check_en[rvfi_check_pkg::field_none] = 1'b0;
    // core and reference disagree on rd after a trap
    if (core_rec.trap || rm_rec.trap) begin
      check_en[rvfi_check_pkg::field_rd_addr]  = 1'b0;
      check_en[rvfi_check_pkg::field_rd_wdata] = 1'b0;
    end
    // x0 writes may carry any data
    if (core_rec.rd1_addr == '0) begin
      check_en[rvfi_check_pkg::field_rd_wdata] = 1'b0;
    end
    // address only means something when there is an access
    if (core_rec.mem_rmask == '0 && core_rec.mem_wmask == '0) begin
      check_en[rvfi_check_pkg::field_mem_addr] = 1'b0;
    end
  end

  // walk from the lowest priority up, so the earliest failing field wins
  always_comb begin
    fail_field = rvfi_check_pkg::field_none;
    for (int i = n_fields - 1; i > 0; i--) begin
      if (check_en[i] && core_v[i] != rm_v[i]) begin
        fail_field = rvfi_check_pkg::rvfi_field_e'(i);
      end
    end
  end

  always_comb begin
    report_d.seq      = pair_i.seq;
    report_d.field    = fail_field;
    report_d.core_val = core_v[fail_field];
    report_d.rm_val   = rm_v[fail_field];
  end

  // counters hold at their maximum
  always_ff @(posedge rvfi_core or negedge rst_n_i) begin
    if (!rst_n_i) begin
      report_valid_o <= 1'b0;
      compared_cnt_o <= '0;
      mismatch_cnt_o <= '0;
    end else begin
      report_valid_o <= pair_valid_i;
      if (pair_valid_i && compared_cnt_o != '1) begin
        compared_cnt_o <= compared_cnt_o + 1'b1;
      end
      if (pair_valid_i && fail_field != rvfi_check_pkg::field_none &&
          mismatch_cnt_o != '1) begin
        mismatch_cnt_o <= mismatch_cnt_o + 1'b1;
      end
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (pair_valid_i) begin
      report_o <= report_d;
    end
  end

  // one report per pair, one cycle later, carrying that pair's number
  report_timing_a: assert property (@(posedge rvfi_core) disable iff (!rst_n_i)
    report_valid_o == $past(pair_valid_i) &&
    (!report_valid_o || report_o.seq == $past(pair_i.seq)));

endmodule

`default_nettype wire

// ==== logic/rvfi_checker_top.sv ====
// step-and-compare checker top level, buffers both rvfi traces, pairs them and reports mismatches
`timescale 1ns/100ps
`default_nettype none

module rvfi_checker_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire                               rvfi_core,
  input  wire                               rst_n_i,
  input  wire                               core_valid_i,
  input  rvfi_check_pkg::rvfi_rec_t         core_rec_i,
  output logic                              core_credit_o,
  input  wire                               rm_valid_i,
  input  rvfi_check_pkg::rvfi_rec_t         rm_rec_i,
  output logic                              rm_credit_o,
  output logic                              report_valid_o,
  output rvfi_check_pkg::rvfi_report_t      report_o,
  output logic [rvfi_check_pkg::seq_w-1:0]  compared_cnt_o,
  output logic [rvfi_check_pkg::seq_w-1:0]  mismatch_cnt_o
);

  rvfi_check_pkg::rvfi_rec_t  core_head;
  rvfi_check_pkg::rvfi_rec_t  rm_head;
  rvfi_check_pkg::rvfi_pair_t pair;
  logic                       core_avail;
  logic                       rm_avail;
  logic                       pop;
  logic                       pair_valid;

  retire_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) core_fifo_i (
    .rvfi_core (rvfi_core),
    .rst_n_i   (rst_n_i),
    .valid_i   (core_valid_i),
    .rec_i     (core_rec_i),
    .pop_i     (pop),
    .head_o    (core_head),
    .avail_o   (core_avail),
    .credit_o  (core_credit_o)
  );

  retire_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rm_fifo_i (
    .rvfi_core (rvfi_core),
    .rst_n_i   (rst_n_i),
    .valid_i   (rm_valid_i),
    .rec_i     (rm_rec_i),
    .pop_i     (pop),
    .head_o    (rm_head),
    .avail_o   (rm_avail),
    .credit_o  (rm_credit_o)
  );

  retire_pairer retire_pairer_i (
    .rvfi_core    (rvfi_core),
    .rst_n_i      (rst_n_i),
    .core_head_i  (core_head),
    .core_avail_i (core_avail),
    .rm_head_i    (rm_head),
    .rm_avail_i   (rm_avail),
    .pop_o        (pop),
    .pair_valid_o (pair_valid),
    .pair_o       (pair)
  );

  retire_comparator retire_comparator_i (
    .rvfi_core      (rvfi_core),
    .rst_n_i        (rst_n_i),
    .pair_valid_i   (pair_valid),
    .pair_i         (pair),
    .report_valid_o (report_valid_o),
    .report_o       (report_o),
    .compared_cnt_o (compared_cnt_o),
    .mismatch_cnt_o (mismatch_cnt_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_rvfi_checker.sv ====
// self-checking testbench for the rvfi checker, compiled from project.f with tb_rvfi_checker as top
`timescale 1ns/100ps
`default_nettype none

module tb_rvfi_checker;

  typedef rvfi_check_pkg::rvfi_rec_t        rec_t;
  typedef rvfi_check_pkg::rvfi_report_t     rep_t;
  typedef rvfi_check_pkg::rvfi_field_e      field_e;
  typedef logic [rvfi_check_pkg::seq_w-1:0] cnt_t;

  localparam int FIFO_DEPTH     = 4;
  // 20 identical, 30 single faults, 7 masking, 10 priority, 24 skew
  localparam int n_pairs        = 91;
  localparam int timeout_cycles = 40 * n_pairs + 200;

  logic rvfi_core;
  logic rst_n_i;
  logic core_valid_i;
  rec_t core_rec_i;
  logic core_credit_o;
  logic rm_valid_i;
  rec_t rm_rec_i;
  logic rm_credit_o;
  logic report_valid_o;
  rep_t report_o;
  cnt_t compared_cnt_o;
  cnt_t mismatch_cnt_o;

  rec_t core_q[$];
  rec_t rm_q[$];
  rep_t exp_q[$];
  int   pair_count   = 0;
  int   report_count = 0;
  int   mismatch_exp = 0;
  int   value_errs   = 0;
  int   other_errs   = 0;
  int   cycle_count  = 0;
  int   core_credits = 0;
  int   rm_credits   = 0;
  bit   core_hold    = 1'b0;
  bit   rm_hold      = 1'b0;

  rvfi_checker_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (
    .rvfi_core      (rvfi_core),
    .rst_n_i        (rst_n_i),
    .core_valid_i   (core_valid_i),
    .core_rec_i     (core_rec_i),
    .core_credit_o  (core_credit_o),
    .rm_valid_i     (rm_valid_i),
    .rm_rec_i       (rm_rec_i),
    .rm_credit_o    (rm_credit_o),
    .report_valid_o (report_valid_o),
    .report_o       (report_o),
    .compared_cnt_o (compared_cnt_o),
    .mismatch_cnt_o (mismatch_cnt_o)
  );

  initial begin : clock_gen
    rvfi_core = 1'b0;
    forever #20 rvfi_core = !rvfi_core;
  end

  function automatic rep_t mism(input field_e f, input logic [31:0] cv, input logic [31:0] rv);
    rep_t rep;
    rep.seq      = '0;
    rep.field    = f;
    rep.core_val = cv;
    rep.rm_val   = rv;
    return rep;
  endfunction

  // expected report of a pair, first failing field in priority order
  function automatic rep_t expect_report(input rec_t c, input rec_t r, input int seq);
    rep_t        rep;
    logic [31:0] rb;
    logic [31:0] wb;
    logic        rd_ok;
    for (int i = 0; i < 4; i++) begin
      rb[i*8 +: 8] = {8{c.mem_rmask[i]}};
      wb[i*8 +: 8] = {8{c.mem_wmask[i]}};
    end
    rd_ok = !c.trap && !r.trap;
    rep = mism(rvfi_check_pkg::field_none, '0, '0);
    if (c.pc_rdata != r.pc_rdata)
      rep = mism(rvfi_check_pkg::field_pc, c.pc_rdata, r.pc_rdata);
    else if (c.insn != r.insn)
      rep = mism(rvfi_check_pkg::field_insn, c.insn, r.insn);
    else if (c.trap != r.trap)
      rep = mism(rvfi_check_pkg::field_trap, 32'(c.trap), 32'(r.trap));
    else if (c.halt != r.halt)
      rep = mism(rvfi_check_pkg::field_halt, 32'(c.halt), 32'(r.halt));
    else if (c.dbg != r.dbg)
      rep = mism(rvfi_check_pkg::field_dbg, 32'(c.dbg), 32'(r.dbg));
    else if (c.dbg_mode != r.dbg_mode)
      rep = mism(rvfi_check_pkg::field_dbg_mode, 32'(c.dbg_mode), 32'(r.dbg_mode));
    else if (c.nmip != r.nmip)
      rep = mism(rvfi_check_pkg::field_nmip, 32'(c.nmip), 32'(r.nmip));
    else if (c.intr != r.intr)
      rep = mism(rvfi_check_pkg::field_intr, 32'(c.intr), 32'(r.intr));
    else if (c.mode != r.mode)
      rep = mism(rvfi_check_pkg::field_mode, 32'(c.mode), 32'(r.mode));
    else if (rd_ok && c.rd1_addr != r.rd1_addr)
      rep = mism(rvfi_check_pkg::field_rd_addr, 32'(c.rd1_addr), 32'(r.rd1_addr));
    else if (rd_ok && c.rd1_addr != 5'd0 && c.rd1_wdata != r.rd1_wdata)
      rep = mism(rvfi_check_pkg::field_rd_wdata, c.rd1_wdata, r.rd1_wdata);
    else if (c.mem_rmask != r.mem_rmask)
      rep = mism(rvfi_check_pkg::field_mem_rmask, 32'(c.mem_rmask), 32'(r.mem_rmask));
    else if (c.mem_wmask != r.mem_wmask)
      rep = mism(rvfi_check_pkg::field_mem_wmask, 32'(c.mem_wmask), 32'(r.mem_wmask));
    else if ((c.mem_rmask != 4'd0 || c.mem_wmask != 4'd0) && c.mem_addr != r.mem_addr)
      rep = mism(rvfi_check_pkg::field_mem_addr, c.mem_addr, r.mem_addr);
    else if ((c.mem_rdata & rb) != (r.mem_rdata & rb))
      rep = mism(rvfi_check_pkg::field_mem_rdata, c.mem_rdata & rb, r.mem_rdata & rb);
    else if ((c.mem_wdata & wb) != (r.mem_wdata & wb))
      rep = mism(rvfi_check_pkg::field_mem_wdata, c.mem_wdata & wb, r.mem_wdata & wb);
    rep.seq = cnt_t'(seq);
    return rep;
  endfunction

  // no trap, a real rd and a read access, so most fields are live
  function automatic rec_t rand_rec();
    logic [223:0] bits;
    rec_t         r;
    bits = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
    r = bits[$bits(rec_t)-1:0];
    r.trap      = 1'b0;
    r.rd1_addr  = 5'($urandom_range(31, 1));
    r.mem_rmask = 4'($urandom_range(15, 1));
    return r;
  endfunction

  function automatic rec_t corrupt(input rec_t rec, input field_e f);
    rec_t r;
    r = rec;
    case (f)
      rvfi_check_pkg::field_pc:        r.pc_rdata  = rec.pc_rdata ^ ($urandom | 32'h1);
      rvfi_check_pkg::field_insn:      r.insn      = rec.insn ^ ($urandom | 32'h1);
      rvfi_check_pkg::field_trap:      r.trap      = !rec.trap;
      rvfi_check_pkg::field_halt:      r.halt      = !rec.halt;
      rvfi_check_pkg::field_dbg:       r.dbg       = rec.dbg ^ 3'($urandom_range(7, 1));
      rvfi_check_pkg::field_dbg_mode:  r.dbg_mode  = !rec.dbg_mode;
      rvfi_check_pkg::field_nmip:      r.nmip      = !rec.nmip;
      rvfi_check_pkg::field_intr:      r.intr      = !rec.intr;
      rvfi_check_pkg::field_mode:      r.mode      = rec.mode ^ 2'($urandom_range(3, 1));
      rvfi_check_pkg::field_rd_addr:   r.rd1_addr  = rec.rd1_addr ^ 5'($urandom_range(31, 1));
      rvfi_check_pkg::field_rd_wdata:  r.rd1_wdata = rec.rd1_wdata ^ ($urandom | 32'h1);
      rvfi_check_pkg::field_mem_rmask: r.mem_rmask = rec.mem_rmask ^ 4'($urandom_range(15, 1));
      rvfi_check_pkg::field_mem_wmask: r.mem_wmask = rec.mem_wmask ^ 4'($urandom_range(15, 1));
      rvfi_check_pkg::field_mem_addr:  r.mem_addr  = rec.mem_addr ^ ($urandom | 32'h1);
      default: ;
    endcase
    return r;
  endfunction

  // expected report goes in before the records can reach the DUT
  task automatic add_pair(input rec_t c, input rec_t r);
    rep_t rep;
    rep = expect_report(c, r, pair_count);
    if (rep.field != rvfi_check_pkg::field_none)
      mismatch_exp++;
    exp_q.push_back(rep);
    core_q.push_back(c);
    rm_q.push_back(r);
    pair_count++;
  endtask

  task automatic check_report(input string name, input rep_t exp_v, input rep_t act_v);
    if (act_v !== exp_v) begin
      value_errs++;
      $display("FAILED %0t %s expected seq=%0d field=%0d core=%h rm=%h", $time, name,
               exp_v.seq, exp_v.field, exp_v.core_val, exp_v.rm_val);
      $display("FAILED %0t %s actual   seq=%0d field=%0d core=%h rm=%h", $time, name,
               act_v.seq, act_v.field, act_v.core_val, act_v.rm_val);
    end
  endtask

  task automatic check_count(input string name, input cnt_t exp_v, input cnt_t act_v);
    if (act_v !== exp_v) begin
      value_errs++;
      $display("FAILED %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
    end
  endtask

  // one side idles while the other fills its buffer and runs out of credits
  task automatic skew_burst(input bit hold_core);
    rec_t c;
    @(negedge rvfi_core);
    core_hold = hold_core;
    rm_hold   = !hold_core;
    repeat (12) begin
      c = rand_rec();
      add_pair(c, c);
    end
    repeat (4 * FIFO_DEPTH) @(negedge rvfi_core);
    core_hold = 1'b0;
    rm_hold   = 1'b0;
    wait (report_count == pair_count);
  endtask

  initial begin : core_sender
    core_credits = FIFO_DEPTH;
    wait (rst_n_i === 1'b1);
    forever begin
      @(posedge rvfi_core);
      #2;
      if (core_credit_o)
        core_credits++;
      if (core_credits > FIFO_DEPTH) begin
        other_errs++;
        $display("core buffer returned a credit that was never spent at %0t", $time);
      end
      core_valid_i = 1'b0;
      if (!core_hold && core_credits > 0 && core_q.size() > 0 &&
          (rm_hold || $urandom_range(3) != 0)) begin
        core_rec_i   = core_q.pop_front();
        core_valid_i = 1'b1;
        core_credits--;
      end
    end
  end

  initial begin : rm_sender
    rm_credits = FIFO_DEPTH;
    wait (rst_n_i === 1'b1);
    forever begin
      @(posedge rvfi_core);
      #2;
      if (rm_credit_o)
        rm_credits++;
      if (rm_credits > FIFO_DEPTH) begin
        other_errs++;
        $display("rm buffer returned a credit that was never spent at %0t", $time);
      end
      rm_valid_i = 1'b0;
      if (!rm_hold && rm_credits > 0 && rm_q.size() > 0 &&
          (core_hold || $urandom_range(3) != 0)) begin
        rm_rec_i   = rm_q.pop_front();
        rm_valid_i = 1'b1;
        rm_credits--;
      end
    end
  end

  // reports are sampled mid-cycle, away from the clock edge
  always @(negedge rvfi_core) begin : compare
    rep_t exp_rep;
    if (rst_n_i && report_valid_o) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("report at %0t arrived with no pair outstanding", $time);
      end else begin
        exp_rep = exp_q.pop_front();
        check_report("report_o", exp_rep, report_o);
      end
      report_count++;
    end
  end

  always @(posedge rvfi_core) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin : watchdog
    wait (cycle_count >= timeout_cycles);
    $display("timeout after %0d cycles, %0d of %0d reports seen", cycle_count,
             report_count, pair_count);
    $display("Regression failed");
    $finish;
  end

  initial begin : main
    rec_t c;
    rec_t r;
    void'($urandom(32'h353c));
    rst_n_i      = 1'b0;
    core_valid_i = 1'b0;
    core_rec_i   = '0;
    rm_valid_i   = 1'b0;
    rm_rec_i     = '0;
    repeat (10) @(posedge rvfi_core);
    #2;
    rst_n_i = 1'b1;

    repeat (20) begin
      c = rand_rec();
      add_pair(c, c);
    end
    repeat (30) begin
      c = rand_rec();
      add_pair(c, corrupt(c, field_e'($urandom_range(14, 1))));
    end

    // trap on both sides hides rd differences
    c = rand_rec();
    c.trap = 1'b1;
    r = c;
    r.rd1_addr  = c.rd1_addr ^ 5'h1;
    r.rd1_wdata = ~c.rd1_wdata;
    add_pair(c, r);
    // x0 write data is ignored
    c = rand_rec();
    c.rd1_addr = '0;
    r = c;
    r.rd1_wdata = ~c.rd1_wdata;
    add_pair(c, r);
    // no access, so the address is free
    c.mem_rmask = '0;
    c.mem_wmask = '0;
    r = c;
    r.mem_addr = ~c.mem_addr;
    add_pair(c, r);
    // bytes outside then inside the masks
    c = rand_rec();
    c.mem_rmask = 4'b0011;
    c.mem_wmask = 4'b1100;
    r = c;
    r.mem_rdata[31:24] = ~c.mem_rdata[31:24];
    add_pair(c, r);
    r.mem_rdata[7:0] = ~c.mem_rdata[7:0];
    add_pair(c, r);
    r = c;
    r.mem_wdata[7:0] = ~c.mem_wdata[7:0];
    add_pair(c, r);
    r.mem_wdata[31:24] = ~c.mem_wdata[31:24];
    add_pair(c, r);

    // several faults per pair, the earliest field must win
    repeat (10) begin
      c = rand_rec();
      r = c;
      repeat (3) r = corrupt(r, field_e'($urandom_range(14, 1)));
      add_pair(c, r);
    end
    wait (report_count == pair_count);

    skew_burst(1'b1);
    skew_burst(1'b0);

    repeat (2) @(negedge rvfi_core);
    check_count("compared_cnt_o", cnt_t'(pair_count), compared_cnt_o);
    check_count("mismatch_cnt_o", cnt_t'(mismatch_exp), mismatch_cnt_o);
    if (exp_q.size() != 0 || core_q.size() != 0 || rm_q.size() != 0) begin
      other_errs++;
      $display("records or expected reports were left over at the end of the run");
    end
    if (core_credits != FIFO_DEPTH || rm_credits != FIFO_DEPTH) begin
      other_errs++;
      $display("senders did not get all credits back, core %0d rm %0d", core_credits,
               rm_credits);
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
logic/rvfi_check_pkg.sv
logic/retire_fifo.sv
logic/retire_pairer.sv
logic/retire_comparator.sv
logic/rvfi_checker_top.sv
dv/tb_rvfi_checker.sv

// ==== Makefile ====
# Verilator build and run of the rvfi checker regression
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rvfi_checker
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
